// ==== dv/cd_tx_asserts.sv ====
// Concurrent checks on the transmit stream, the buffer release pulse and
// the reset state, bound into the transmit top level.
`timescale 1ns/1ps

module cd_tx_asserts (
    input logic       clk,
    input logic       reset_n,
    input logic       tx_valid,
    input logic       tx_ready,
    input logic [7:0] tx_data,
    input logic       rd_done,
    input logic       unread
);

    int fail_cnt = 0;    // Read by the testbench at the end.

    // A stalled byte holds until the sink takes it.
    stream_hold: assert property (@(posedge clk) disable iff (!reset_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
    else begin
        fail_cnt++;
        $error("Stalled stream byte changed or dropped before acceptance");
    end

    release_dirty: assert property (@(posedge clk) disable iff (!reset_n)
        rd_done |-> unread)
    else begin
        fail_cnt++;
        $error("Buffer release pulse while no frame was pending");
    end

    reset_quiet: assert property (@(posedge clk) !reset_n |=> !tx_valid)
    else begin
        fail_cnt++;
        $error("Stream valid seen during reset");
    end

endmodule

bind cd_tx_top cd_tx_asserts i_asserts (
    .clk      (clk),
    .reset_n  (reset_n),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx_data  (tx_data),
    .rd_done  (rd_done),
    .unread   (unread)
);

// ==== dv/tb_cd_tx_top.sv ====
// CDBUS transmit path testbench with AXI4-Lite host tasks, a stream sink,
// a table of frames and a CRC-16 reference model.
`timescale 1ns/1ps

module tb_cd_tx_top;

    localparam int TIMEOUT  = 4000;    // Cycles or polls per wait loop.
    localparam int NUM_ROWS = 7;

    typedef logic [7:0] byte_q_t [$];

    typedef struct packed {
        logic [7:0] len;
        logic [7:0] src;
        logic [7:0] dst;
        logic [1:0] mode;         // 0 ready, 1 LFSR duty, 2 held low.
        logic       accept;       // Commit should be taken.
        logic       wait_free;    // Poll buf_full before the commit.
        logic       drain;        // Collect and compare afterwards.
    } row_t;

    row_t frames [NUM_ROWS] = '{
        '{8'd5,   8'h11, 8'h21, 2'd0, 1'b1, 1'b1, 1'b1},
        '{8'd40,  8'h12, 8'h22, 2'd1, 1'b1, 1'b1, 1'b0},
        '{8'd12,  8'h13, 8'h23, 2'd1, 1'b1, 1'b1, 1'b1},    // Overlaps the one before.
        '{8'd253, 8'h14, 8'h24, 2'd1, 1'b1, 1'b1, 1'b1},
        '{8'd0,   8'h15, 8'h25, 2'd0, 1'b1, 1'b1, 1'b1},
        '{8'd8,   8'h16, 8'h26, 2'd2, 1'b1, 1'b1, 1'b0},
        '{8'd9,   8'h17, 8'h27, 2'd2, 1'b0, 1'b0, 1'b1}     // Other buffer still full.
    };

    logic                clk = 1'b0;
    logic                reset_n;
    cd_tx_pkg::axil_aw_t aw;
    logic                aw_valid;
    logic                aw_ready;
    cd_tx_pkg::axil_w_t  w;
    logic                w_valid;
    logic                w_ready;
    cd_tx_pkg::axil_b_t  b;
    logic                b_valid;
    logic                b_ready;
    cd_tx_pkg::axil_ar_t ar;
    logic                ar_valid;
    logic                ar_ready;
    cd_tx_pkg::axil_r_t  r;
    logic                r_valid;
    logic                r_ready;
    logic [7:0]          tx_data;
    logic                tx_valid;
    logic                tx_ready = 1'b0;

    logic [1:0]  ready_mode = 2'd0;
    logic [15:0] pay_lfsr = 16'd35;
    logic [15:0] rdy_lfsr = 16'd35;
    byte_q_t     rx_q;
    byte_q_t     exp_q;
    int          value_errs = 0;
    int          timeouts = 0;

    cd_tx_top #(
        .B_WIDTH(9)
    ) i_dut (
        .clk      (clk),
        .reset_n  (reset_n),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b        (b),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

    always #2 clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Bitwise Modbus CRC over header and payload.
    function automatic logic [15:0] crc16_model(input byte_q_t bytes);
        logic [15:0] c;
        logic        fb;
        c = cd_tx_pkg::CRC_INIT;
        foreach (bytes[n]) begin
            for (int i = 0; i < 8; i++) begin
                fb = c[0] ^ bytes[n][i];
                c  = c >> 1;
                if (fb) begin
                    c = c ^ cd_tx_pkg::CRC_POLY;
                end
            end
        end
        return c;
    endfunction

    task automatic next_payload_byte(output logic [7:0] v);
        for (int i = 0; i < 8; i++) begin
            pay_lfsr = lfsr_step(pay_lfsr);
            v[i]     = pay_lfsr[0];
        end
    endtask

    task automatic print_counts();
        $display("Errors: %0d wrong values, %0d timeouts, %0d assertion failures",
                 value_errs, timeouts, i_dut.i_asserts.fail_cnt);
    endtask

    task automatic abort_on_timeout(input string what);
        timeouts++;
        $display("Timeout: no progress while waiting for %s", what);
        print_counts();
        $display("Test failures found");
        $finish;
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            value_errs++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Sink ready follows the mode of the current table row.
    always @(posedge clk) begin
        if (ready_mode == 2'd1) begin
            rdy_lfsr = lfsr_step(rdy_lfsr);
            tx_ready <= rdy_lfsr[0];
        end else begin
            tx_ready <= (ready_mode == 2'd0);
        end
    end

    always @(negedge clk) begin
        if (reset_n && tx_valid && tx_ready) begin
            rx_q.push_back(tx_data);    // Transfers at the next edge.
        end
    end

    task automatic write_reg(input logic [11:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int   cycles;
        logic aw_done;
        logic w_done;
        cycles  = 0;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(posedge clk);
        aw.addr  <= addr;
        aw_valid <= 1'b1;
        w.data   <= data;
        w.strb   <= 4'hF;
        w_valid  <= 1'b1;
        while (!(aw_done && w_done)) begin
            @(negedge clk);
            if (aw_valid && aw_ready) begin
                aw_done = 1'b1;
            end
            if (w_valid && w_ready) begin
                w_done = 1'b1;
            end
            @(posedge clk);
            if (aw_done) begin
                aw_valid <= 1'b0;
            end
            if (w_done) begin
                w_valid <= 1'b0;
            end
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_on_timeout("AXI write address and data handshakes");
            end
        end
        cycles = 0;
        @(negedge clk);
        while (!b_valid) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_on_timeout("AXI write response");
            end
            @(negedge clk);
        end
        resp = b.resp;
        @(posedge clk);
    endtask

    task automatic read_reg(input logic [11:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int cycles;
        cycles = 0;
        @(posedge clk);
        ar.addr  <= addr;
        ar_valid <= 1'b1;
        @(negedge clk);
        while (!ar_ready) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_on_timeout("AXI read address handshake");
            end
            @(negedge clk);
        end
        @(posedge clk);
        ar_valid <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!r_valid) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_on_timeout("AXI read data");
            end
            @(negedge clk);
        end
        data = r.data;
        resp = r.resp;
        @(posedge clk);
    endtask

    task automatic poll_status_clear(input int bit_idx);
        logic [31:0] st;
        logic [1:0]  resp;
        int          polls;
        polls = 0;
        read_reg(cd_tx_pkg::REG_STATUS, st, resp);
        while (st[bit_idx]) begin
            polls++;
            if (polls > TIMEOUT) begin
                abort_on_timeout("a status bit to clear");
            end
            read_reg(cd_tx_pkg::REG_STATUS, st, resp);
        end
    endtask

    task automatic wait_stream(input int count);
        int cycles;
        cycles = 0;
        while (rx_q.size() < count) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_on_timeout("stream bytes");
            end
            @(posedge clk);
        end
    endtask

    initial begin
        row_t        cur;
        byte_q_t     frame;
        logic [31:0] rdata;
        logic [1:0]  resp;
        logic [15:0] crc;
        logic [7:0]  pbyte;

        reset_n  <= 1'b0;
        aw       <= '0;
        aw_valid <= 1'b0;
        w        <= '0;
        w_valid  <= 1'b0;
        b_ready  <= 1'b1;
        ar       <= '0;
        ar_valid <= 1'b0;
        r_ready  <= 1'b1;
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;

        // Idle status, data window reads and unmapped addresses.
        read_reg(cd_tx_pkg::REG_STATUS, rdata, resp);
        expect_eq("status", rdata, 32'd0);
        expect_eq("r.resp", 32'(resp), 32'(cd_tx_pkg::RESP_OKAY));
        read_reg(12'h104, rdata, resp);
        expect_eq("r.data", rdata, 32'd0);
        expect_eq("r.resp", 32'(resp), 32'(cd_tx_pkg::RESP_OKAY));
        read_reg(12'h008, rdata, resp);
        expect_eq("r.resp", 32'(resp), 32'(cd_tx_pkg::RESP_SLVERR));
        read_reg(12'h500, rdata, resp);
        expect_eq("r.resp", 32'(resp), 32'(cd_tx_pkg::RESP_SLVERR));
        write_reg(12'h00C, 32'd1, resp);
        expect_eq("b.resp", 32'(resp), 32'(cd_tx_pkg::RESP_SLVERR));
        write_reg(12'h500, 32'h5A, resp);
        expect_eq("b.resp", 32'(resp), 32'(cd_tx_pkg::RESP_SLVERR));
        write_reg(cd_tx_pkg::REG_CTRL, 32'd0, resp);
        expect_eq("b.resp", 32'(resp), 32'(cd_tx_pkg::RESP_OKAY));
        read_reg(cd_tx_pkg::REG_STATUS, rdata, resp);
        expect_eq("status", rdata, 32'd0);
        @(negedge clk);
        expect_eq("tx_valid", 32'(tx_valid), 32'd0);
        expect_eq("stream byte count", 32'(rx_q.size()), 32'd0);

        for (int row = 0; row < NUM_ROWS; row++) begin
            cur        = frames[row];
            ready_mode <= cur.mode;
            frame.delete();
            frame.push_back(cur.src);
            frame.push_back(cur.dst);
            frame.push_back(cur.len);
            for (int k = 0; k < int'(cur.len); k++) begin
                next_payload_byte(pbyte);
                frame.push_back(pbyte);
            end
            foreach (frame[k]) begin
                write_reg(cd_tx_pkg::REG_DATA + 12'(4 * k), {24'd0, frame[k]}, resp);
                expect_eq("b.resp", 32'(resp), 32'(cd_tx_pkg::RESP_OKAY));
            end
            if (cur.wait_free) begin
                poll_status_clear(1);
            end else begin
                read_reg(cd_tx_pkg::REG_STATUS, rdata, resp);
                expect_eq("status", rdata, 32'd3);    // Pending and full.
            end
            write_reg(cd_tx_pkg::REG_CTRL, 32'd1, resp);
            expect_eq("b.resp", 32'(resp), 32'(cd_tx_pkg::RESP_OKAY));
            if (cur.accept) begin
                crc = crc16_model(frame);
                frame.push_back(crc[7:0]);
                frame.push_back(crc[15:8]);
                foreach (frame[k]) begin
                    exp_q.push_back(frame[k]);
                end
            end
            if (cur.drain) begin
                if (cur.mode == 2'd2) begin
                    ready_mode <= 2'd0;    // Release the stalled stream.
                end
                wait_stream(exp_q.size());
                poll_status_clear(0);
                read_reg(cd_tx_pkg::REG_STATUS, rdata, resp);
                expect_eq("status", rdata, 32'd0);
                expect_eq("stream byte count", 32'(rx_q.size()), 32'(exp_q.size()));
                foreach (exp_q[i]) begin
                    if (i < rx_q.size()) begin
                        expect_eq($sformatf("tx_data[%0d]", i), {24'd0, rx_q[i]},
                                  {24'd0, exp_q[i]});
                    end
                end
                rx_q.delete();
                exp_q.delete();
            end
        end

        print_counts();
        if (value_errs == 0 && i_dut.i_asserts.fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== hw/cd_axil_regs.sv ====
// AXI4-Lite register slave: control, status and the transmit data window.
`timescale 1ns/1ps

module cd_axil_regs (
    input  logic                clk,
    input  logic                reset_n,

    input  cd_tx_pkg::axil_aw_t aw,
    input  logic                aw_valid,
    output logic                aw_ready,
    input  cd_tx_pkg::axil_w_t  w,
    input  logic                w_valid,
    output logic                w_ready,
    output cd_tx_pkg::axil_b_t  b,
    output logic                b_valid,
    input  logic                b_ready,
    input  cd_tx_pkg::axil_ar_t ar,
    input  logic                ar_valid,
    output logic                ar_ready,
    output cd_tx_pkg::axil_r_t  r,
    output logic                r_valid,
    input  logic                r_ready,

    input  logic                tx_pending,
    input  logic                buf_full,
    output cd_tx_pkg::ram_wr_t  ram_wr,
    output logic                commit
);

    cd_tx_pkg::axil_aw_t aw_q;
    cd_tx_pkg::axil_w_t  w_q;
    logic                aw_held;
    logic                w_held;
    logic                aw_hs;
    logic                w_hs;
    logic                ar_hs;
    logic                wr_fire;
    logic                b_valid_n;
    logic                r_valid_n;
    logic [11:0]         wr_addr;
    cd_tx_pkg::axil_w_t  wr_cur;
    logic                wr_window;
    logic                wr_ctrl;
    logic                wr_mapped;
    logic                rd_mapped;

    function automatic logic in_window(input logic [11:0] a);
        return (a >= cd_tx_pkg::REG_DATA) && (a < cd_tx_pkg::DATA_END);
    endfunction

    function automatic logic [7:0] window_offset(input logic [11:0] a);
        logic [11:0] rel;
        rel = a - cd_tx_pkg::REG_DATA;
        return rel[9:2];    // One byte per 32-bit word.
    endfunction

    assign aw_hs = aw_valid & aw_ready;
    assign w_hs  = w_valid & w_ready;
    assign ar_hs = ar_valid & ar_ready;

    // Fire as soon as both halves are in, either latched or arriving now.
    assign wr_fire = (aw_held | aw_hs) & (w_held | w_hs);
    assign wr_addr = aw_held ? aw_q.addr : aw.addr;
    assign wr_cur  = w_held ? w_q : w;

    assign wr_window = in_window(wr_addr);
    assign wr_ctrl   = wr_addr == cd_tx_pkg::REG_CTRL;
    assign wr_mapped = wr_window | wr_ctrl | (wr_addr == cd_tx_pkg::REG_STATUS);
    assign rd_mapped = in_window(ar.addr) | (ar.addr == cd_tx_pkg::REG_CTRL)
                     | (ar.addr == cd_tx_pkg::REG_STATUS);

    assign b_valid_n = wr_fire | (b_valid & ~b_ready);
    assign r_valid_n = ar_hs | (r_valid & ~r_ready);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            ram_wr   <= '0;
            commit   <= 1'b0;
        end else begin
            aw_held  <= ~wr_fire & (aw_held | aw_hs);
            w_held   <= ~wr_fire & (w_held | w_hs);
            b_valid  <= b_valid_n;
            aw_ready <= ~b_valid_n & ~(~wr_fire & (aw_held | aw_hs));
            w_ready  <= ~b_valid_n & ~(~wr_fire & (w_held | w_hs));
            r_valid  <= r_valid_n;
            ar_ready <= ~r_valid_n;    // One read in flight.

            ram_wr.en   <= wr_fire & wr_window & wr_cur.strb[0];
            ram_wr.addr <= window_offset(wr_addr);
            ram_wr.data <= wr_cur.data[7:0];
            commit      <= wr_fire & wr_ctrl & wr_cur.strb[0] & wr_cur.data[0];
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            aw_q <= aw;
        end
        if (w_hs) begin
            w_q <= w;
        end
        if (wr_fire) begin
            b.resp <= wr_mapped ? cd_tx_pkg::RESP_OKAY : cd_tx_pkg::RESP_SLVERR;
        end
        if (ar_hs) begin
            r.data <= (ar.addr == cd_tx_pkg::REG_STATUS) ?
                      {30'd0, buf_full, tx_pending} : 32'd0;
            r.resp <= rd_mapped ? cd_tx_pkg::RESP_OKAY : cd_tx_pkg::RESP_SLVERR;
        end
    end

endmodule

// ==== hw/cd_sdpram.sv ====
// Simple dual-port byte RAM with a registered read port.
`timescale 1ns/1ps

module cd_sdpram #(
    parameter int A_WIDTH = 9
) (
    input  logic               clk,
    input  logic               cen,    // Active low.
    input  logic [A_WIDTH-1:0] ra,
    output logic [7:0]         rd,
    input  logic [A_WIDTH-1:0] wa,
    input  logic [7:0]         wd,
    input  logic               wen     // Active low.
);

    logic [7:0] mem [0:(2**A_WIDTH)-1];

    always_ff @(posedge clk) begin
        if (!cen) begin
            if (!wen) begin
                mem[wa] <= wd;
            end else begin
                rd <= mem[ra];    // Holds its value when not read.
            end
        end
    end

endmodule

// ==== hw/cd_tx_framer.sv ====
// Transmit framer: reads a committed frame, streams it with valid/ready
// and appends the CRC-16, low byte first.
`timescale 1ns/1ps

module cd_tx_framer (
    input  logic       clk,
    input  logic       reset_n,

    input  logic       unread,
    input  logic [7:0] rd_byte,
    input  logic       rd_valid,
    output logic [7:0] rd_addr,
    output logic       rd_en,
    output logic       rd_done,

    output logic [7:0] tx_data,
    output logic       tx_valid,
    input  logic       tx_ready
);

    cd_tx_pkg::framer_state_e state;
    logic [8:0]  rd_ptr;     // Next offset to fetch.
    logic [8:0]  end_off;    // Last offset, length plus 2.
    logic        rd_pend;    // Read issued last cycle.
    logic        pf_full;
    logic [7:0]  pf_data;
    logic [15:0] crc;
    logic [15:0] crc_upd;
    logic        in_data;
    logic        tx_fire;
    logic        out_free;
    logic        arrive;
    logic        rd_retry;
    logic        rd_left;
    logic        take_pf;
    logic        take_rd;
    logic        fill_pf;
    logic        data_end;

    function automatic logic [15:0] crc_step(input logic [15:0] c, input logic [7:0] d);
        logic [15:0] v;
        v = c ^ {8'h00, d};
        for (int i = 0; i < 8; i++) begin
            v = v[0] ? ((v >> 1) ^ cd_tx_pkg::CRC_POLY) : (v >> 1);
        end
        return v;
    endfunction

    assign in_data  = state == cd_tx_pkg::FR_DATA;
    assign tx_fire  = tx_valid & tx_ready;
    assign out_free = ~tx_valid | tx_ready;
    assign arrive   = rd_pend & rd_valid;
    assign rd_retry = rd_pend & ~rd_valid;    // Lost to a host write.
    assign rd_left  = rd_ptr <= end_off;

    assign take_pf  = in_data & out_free & pf_full;
    assign take_rd  = in_data & out_free & ~pf_full & arrive;
    assign fill_pf  = in_data & ~out_free & arrive;
    assign data_end = in_data & out_free & ~pf_full & ~rd_pend & ~rd_left;
    assign crc_upd  = (in_data & tx_fire) ? crc_step(crc, tx_data) : crc;

    // One fetch at a time, and only with the prefetch slot free.
    assign rd_en = ((state == cd_tx_pkg::FR_IDLE) & unread)
                 | ((state == cd_tx_pkg::FR_LEN) & rd_retry)
                 | (in_data & (~rd_pend | rd_retry) & ~pf_full & rd_left);
    assign rd_addr = in_data ? rd_ptr[7:0] : 8'd2;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= cd_tx_pkg::FR_IDLE;
            rd_pend  <= 1'b0;
            rd_ptr   <= '0;
            pf_full  <= 1'b0;
            tx_valid <= 1'b0;
            rd_done  <= 1'b0;
        end else begin
            rd_pend <= rd_en;
            rd_done <= 1'b0;
            case (state)
                cd_tx_pkg::FR_IDLE: begin
                    if (unread) begin
                        state <= cd_tx_pkg::FR_LEN;
                    end
                end
                cd_tx_pkg::FR_LEN: begin
                    if (arrive) begin
                        rd_ptr <= '0;
                        state  <= cd_tx_pkg::FR_DATA;
                    end
                end
                cd_tx_pkg::FR_DATA: begin
                    if (arrive) begin
                        rd_ptr <= rd_ptr + 9'd1;
                    end
                    if (take_pf || take_rd || data_end) begin
                        tx_valid <= 1'b1;
                    end else if (out_free) begin
                        tx_valid <= 1'b0;
                    end
                    if (take_pf) begin
                        pf_full <= 1'b0;
                    end else if (fill_pf) begin
                        pf_full <= 1'b1;
                    end
                    if (data_end) begin
                        state <= cd_tx_pkg::FR_CRC_LO;
                    end
                end
                cd_tx_pkg::FR_CRC_LO: begin
                    if (tx_fire) begin
                        state <= cd_tx_pkg::FR_CRC_HI;
                    end
                end
                cd_tx_pkg::FR_CRC_HI: begin
                    if (tx_fire) begin
                        tx_valid <= 1'b0;
                        rd_done  <= 1'b1;    // Frees the buffer.
                        state    <= cd_tx_pkg::FR_DONE;
                    end
                end
                default: begin
                    state <= cd_tx_pkg::FR_IDLE;    // Let unread settle.
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cd_tx_pkg::FR_LEN && arrive) begin
            end_off <= {1'b0, rd_byte} + 9'd2;
        end
        if (state == cd_tx_pkg::FR_IDLE) begin
            crc <= cd_tx_pkg::CRC_INIT;
        end else if (in_data) begin
            crc <= crc_upd;
        end
        if (fill_pf) begin
            pf_data <= rd_byte;
        end
        if (take_pf) begin
            tx_data <= pf_data;
        end else if (take_rd) begin
            tx_data <= rd_byte;
        end else if (data_end) begin
            tx_data <= crc_upd[7:0];    // Includes the last data byte.
        end else if (state == cd_tx_pkg::FR_CRC_LO && tx_fire) begin
            tx_data <= crc[15:8];
        end
    end

endmodule

// ==== hw/cd_tx_pkg.sv ====
// RAM write request, AXI4-Lite channel payloads, register map, framer states
// and CRC-16 constants shared by the CDBUS transmit path.

package cd_tx_pkg;

    typedef struct packed {
        logic       en;
        logic [7:0] addr;    // Byte offset within a buffer.
        logic [7:0] data;
    } ram_wr_t;

    typedef struct packed {
        logic [11:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axil_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    typedef struct packed {
        logic [11:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axil_r_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

    typedef enum logic [11:0] {
        REG_CTRL   = 12'h000,    // Bit 0 requests a commit.
        REG_STATUS = 12'h004,    // Bit 0 tx_pending, bit 1 buf_full.
        REG_DATA   = 12'h100     // First word of the data window.
    } reg_addr_e;

    // One past the last word of the 256-word data window.
    localparam logic [11:0] DATA_END = 12'h500;

    typedef enum logic [2:0] {
        FR_IDLE,
        FR_LEN,
        FR_DATA,
        FR_CRC_LO,
        FR_CRC_HI,
        FR_DONE
    } framer_state_e;

    localparam logic [15:0] CRC_INIT = 16'hFFFF;
    localparam logic [15:0] CRC_POLY = 16'hA001;    // Reflected Modbus polynomial.

endpackage

// ==== hw/cd_tx_ram.sv ====
// Ping-pong transmit buffer: two frame buffers in one RAM, dirty flags
// and read/write buffer selection.
`timescale 1ns/1ps

module cd_tx_ram #(
    parameter int B_WIDTH = 9    // Total address width, two buffers.
) (
    input  logic               clk,
    input  logic               reset_n,

    input  logic [7:0]         rd_addr,
    input  logic               rd_en,
    input  logic               rd_done,
    output logic [7:0]         rd_byte,
    output logic               rd_valid,
    output logic               unread,

    input  cd_tx_pkg::ram_wr_t ram_wr,
    input  logic               commit,
    output logic               buf_full
);

    logic       rd_sel;
    logic       wr_sel;
    logic [1:0] dirty;

    assign unread   = dirty[rd_sel];
    assign buf_full = dirty[~wr_sel];    // A commit now would be dropped.

    // One shared enable, so a write in the same cycle steals the read.
    cd_sdpram #(
        .A_WIDTH(B_WIDTH)
    ) i_buf (
        .clk (clk),
        .cen (~rd_en & ~ram_wr.en),
        .ra  ({rd_sel, rd_addr[B_WIDTH-2:0]}),
        .rd  (rd_byte),
        .wa  ({wr_sel, ram_wr.addr[B_WIDTH-2:0]}),
        .wd  (ram_wr.data),
        .wen (~ram_wr.en)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en & ~ram_wr.en;    // Low marks a collided read.
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_sel <= 1'b0;
            wr_sel <= 1'b0;
            dirty  <= 2'b00;
        end else begin
            if (commit && !dirty[~wr_sel]) begin
                dirty[wr_sel] <= 1'b1;
                wr_sel        <= ~wr_sel;
            end

            // Read and write sides never point at the same dirty bit here.
            if (rd_done && dirty[rd_sel]) begin
                dirty[rd_sel] <= 1'b0;
                rd_sel        <= ~rd_sel;
            end
        end
    end

endmodule

// ==== hw/cd_tx_top.sv ====
// Transmit path top level: AXI4-Lite register slave, ping-pong RAM, framer.
`timescale 1ns/1ps

module cd_tx_top #(
    parameter int B_WIDTH = 9
) (
    input  logic                clk,
    input  logic                reset_n,

    input  cd_tx_pkg::axil_aw_t aw,
    input  logic                aw_valid,
    output logic                aw_ready,
    input  cd_tx_pkg::axil_w_t  w,
    input  logic                w_valid,
    output logic                w_ready,
    output cd_tx_pkg::axil_b_t  b,
    output logic                b_valid,
    input  logic                b_ready,
    input  cd_tx_pkg::axil_ar_t ar,
    input  logic                ar_valid,
    output logic                ar_ready,
    output cd_tx_pkg::axil_r_t  r,
    output logic                r_valid,
    input  logic                r_ready,

    output logic [7:0]          tx_data,
    output logic                tx_valid,
    input  logic                tx_ready
);

    cd_tx_pkg::ram_wr_t ram_wr;
    logic               commit;
    logic               buf_full;
    logic               unread;
    logic [7:0]         rd_addr;
    logic               rd_en;
    logic [7:0]         rd_byte;
    logic               rd_valid;
    logic               rd_done;

    cd_axil_regs i_regs (
        .clk        (clk),
        .reset_n    (reset_n),
        .aw         (aw),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .w          (w),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .b          (b),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .ar         (ar),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .r          (r),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .tx_pending (unread),
        .buf_full   (buf_full),
        .ram_wr     (ram_wr),
        .commit     (commit)
    );

    cd_tx_ram #(
        .B_WIDTH(B_WIDTH)
    ) i_ram (
        .clk      (clk),
        .reset_n  (reset_n),
        .rd_addr  (rd_addr),
        .rd_en    (rd_en),
        .rd_done  (rd_done),
        .rd_byte  (rd_byte),
        .rd_valid (rd_valid),
        .unread   (unread),
        .ram_wr   (ram_wr),
        .commit   (commit),
        .buf_full (buf_full)
    );

    cd_tx_framer i_framer (
        .clk      (clk),
        .reset_n  (reset_n),
        .unread   (unread),
        .rd_byte  (rd_byte),
        .rd_valid (rd_valid),
        .rd_addr  (rd_addr),
        .rd_en    (rd_en),
        .rd_done  (rd_done),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the transmit path testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_cd_tx_top -f sim.f -o tb_cd_tx_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_cd_tx_top +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF 'All tests passed!'; then
    echo "RESULT: PASS"
    exit 0
fi
echo "RESULT: FAIL"
exit 1

// ==== sim.f ====
hw/cd_tx_pkg.sv
hw/cd_sdpram.sv
hw/cd_tx_ram.sv
hw/cd_axil_regs.sv
hw/cd_tx_framer.sv
hw/cd_tx_top.sv
dv/cd_tx_asserts.sv
dv/tb_cd_tx_top.sv
